/* files.f */
source/rd_sched_pkg.sv
source/rd_data_pkg.sv
source/sync_fifo.sv
source/rd_addr_scheduler.sv
source/rd_beat_packer.sv
source/rd_slice_dispatcher.sv
source/rd_fifo_arbiter.sv
sim/tb_clk_gen.sv
sim/rd_fifo_arbiter_checker.sv
sim/rd_fifo_arbiter_tb.sv

/* sim/rd_fifo_arbiter_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_fifo_arbiter_tb
  import rd_sched_pkg::*, rd_data_pkg::*;
();

  localparam int N_ROUNDS    = 8;
  localparam int EMPTY_ROUND = 3;
  localparam int WATCHDOG_NS = N_ROUNDS * 2000;

  logic              sys_clk;
  logic              sys_rst;
  logic              phy_init_done;
  logic [CH_NUM-1:0] ch_req;
  addr_t             ch_addr [CH_NUM];
  level_t            ch_level [CH_NUM];
  logic              addr_pop;
  logic              beat_wr;
  beat_t             beat;
  logic [CH_NUM-1:0] ch_addr_en;
  addr_t             rd_addr;
  logic              rd_addr_valid;
  logic              rd_addr_empty;
  logic [CH_NUM-1:0] ch_slice_wr;
  slice_t            ch_slice;
  logic              round_done;

  // reference model and memory model state
  integer      seed;
  int          want [CH_NUM];
  int          acc [CH_NUM];
  int          deliv [CH_NUM];
  int          hold [CH_NUM];
  logic [26:0] addr_cnt [CH_NUM];
  addr_t       slice_q [$];
  addr_t       pop_q [$];
  addr_t       mem_q [$];
  int          mem_due [$];
  logic        beat_hi;
  logic        init_req;
  logic        done_seen;
  int          last_ch;
  int          cyc;
  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;

  tb_clk_gen u_clk (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst)
  );

  rd_fifo_arbiter dut (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .phy_init_done_i (phy_init_done),
    .ch_req_i        (ch_req),
    .ch_addr_i       (ch_addr),
    .ch_level_i      (ch_level),
    .rd_addr_pop_i   (addr_pop),
    .rd_beat_wr_i    (beat_wr),
    .rd_beat_i       (beat),
    .ch_addr_en_o    (ch_addr_en),
    .rd_addr_o       (rd_addr),
    .rd_addr_valid_o (rd_addr_valid),
    .rd_addr_empty_o (rd_addr_empty),
    .ch_slice_wr_o   (ch_slice_wr),
    .ch_slice_o      (ch_slice),
    .round_done_o    (round_done)
  );

  bind rd_fifo_arbiter rd_fifo_arbiter_checker u_checker (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .ch_addr_en_i    (ch_addr_en_o),
    .ch_slice_wr_i   (ch_slice_wr_o),
    .ch_level_i      (ch_level_i),
    .rd_addr_valid_i (rd_addr_valid_o),
    .round_done_i    (round_done_o)
  );

  function automatic int rand_between(int lo, int hi);
    return lo + int'(($random(seed) & 32'h7fff_ffff) % (hi - lo + 1));
  endfunction

  // controller beat holds index, spare bit, address, two spare bits and inverted address
  function automatic beat_t make_beat(addr_t a, logic idx);
    return {idx, 1'b0, a, 2'b00, ~a};
  endfunction

  task automatic value_error(string what, logic [127:0] exp, logic [127:0] act);
    $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, exp, act);
    test_errors++;
    errors++;
  endtask

  task automatic plain_error(string msg);
    $display("[ERROR] %s: %s", test_name, msg);
    test_errors++;
    errors++;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors != 0)
      tests_failed++;
    $display("test %s %s", test_name, (test_errors == 0) ? "passed" : "failed");
  endtask

  task automatic load_round(logic empty);
    for (int c = 0; c < CH_NUM; c++)
    begin
      want[c]  = empty ? 0 : rand_between(0, 10);
      acc[c]   = 0;
      deliv[c] = 0;
    end
    last_ch = 0;
  endtask

  // ********************
  // stimulus
  // ********************
  task automatic drive_inputs();
    phy_init_done = init_req;
    for (int c = 0; c < CH_NUM; c++)
    begin
      ch_req[c]  = (acc[c] < want[c]);
      ch_addr[c] = {ch_idx_t'(c), addr_cnt[c]};
      // now and then a channel fills up for a few cycles
      if (hold[c] == 0 && rand_between(0, 15) == 0)
        hold[c] = rand_between(2, 8);
      if (hold[c] > 0)
      begin
        hold[c]--;
        ch_level[c] = level_t'(LEVEL_LIMIT + rand_between(0, 3));
      end
      else
        ch_level[c] = level_t'(rand_between(0, LEVEL_LIMIT - 1));
    end
    addr_pop = (rand_between(0, 1) == 1);
    // in order return with the high beat right after the low beat
    beat_wr = 1'b0;
    beat    = '0;
    if (beat_hi)
    begin
      beat_wr = 1'b1;
      beat    = make_beat(mem_q.pop_front(), 1'b1);
      void'(mem_due.pop_front());
      beat_hi = 1'b0;
    end
    else if (mem_q.size() > 0 && mem_due[0] <= cyc)
    begin
      beat_wr = 1'b1;
      beat    = make_beat(mem_q[0], 1'b0);
      beat_hi = 1'b1;
    end
  endtask

  // ********************
  // response checks
  // ********************
  task automatic sample_outputs();
    addr_t  a;
    slice_t exp_slice;
    for (int c = 0; c < CH_NUM; c++)
    begin
      if (ch_addr_en[c])
      begin
        if (!ch_req[c])
          plain_error($sformatf("address enable on channel %0d without a request", c));
        if (c < last_ch)
          value_error("channel order", last_ch, c);
        if (acc[c] >= SLICE_NUM)
          plain_error($sformatf("channel %0d gave more than %0d addresses", c, SLICE_NUM));
        last_ch = c;
        acc[c]++;
        slice_q.push_back(ch_addr[c]);
        pop_q.push_back(ch_addr[c]);
        addr_cnt[c]++;
      end
      if (ch_slice_wr[c])
      begin
        if (slice_q.size() == 0)
          plain_error($sformatf("slice written to channel %0d with no address pending", c));
        else
        begin
          a         = slice_q.pop_front();
          exp_slice = {make_beat(a, 1'b1), make_beat(a, 1'b0)};
          if (c != int'(a[29:27]))
            value_error("slice channel", a[29:27], c);
          if (ch_slice !== exp_slice)
            value_error("slice data", exp_slice, ch_slice);
          deliv[c]++;
        end
      end
    end
    if (rd_addr_valid)
    begin
      if (pop_q.size() == 0)
        plain_error("address left the queue although none was accepted");
      else
      begin
        a = pop_q.pop_front();
        if (rd_addr !== a)
          value_error("popped address", a, rd_addr);
        mem_q.push_back(rd_addr);
        mem_due.push_back(cyc + rand_between(1, 12));
      end
    end
    if (round_done)
      done_seen = 1'b1;
  endtask

  task automatic step();
    @(negedge sys_clk);
    drive_inputs();
    #1;
    sample_outputs();
    cyc++;
  endtask

  task automatic check_round_end();
    int exp_acc;
    for (int c = 0; c < CH_NUM; c++)
    begin
      exp_acc = (want[c] < SLICE_NUM) ? want[c] : SLICE_NUM;
      if (acc[c] != exp_acc)
        value_error($sformatf("ch%0d addresses", c), exp_acc, acc[c]);
      if (deliv[c] != acc[c])
        value_error($sformatf("ch%0d slices", c), acc[c], deliv[c]);
    end
    if (slice_q.size() != 0)
      plain_error("round ended before all of its slices were delivered");
  endtask

  initial
  begin
    seed          = 32'hd2f5dc8a;
    phy_init_done = 1'b0;
    ch_req        = '0;
    addr_pop      = 1'b0;
    beat_wr       = 1'b0;
    beat          = '0;
    for (int c = 0; c < CH_NUM; c++)
    begin
      ch_addr[c]  = '0;
      ch_level[c] = '0;
      want[c]     = 0;
      acc[c]      = 0;
      deliv[c]    = 0;
      hold[c]     = 0;
      addr_cnt[c] = '0;
    end
    beat_hi      = 1'b0;
    init_req     = 1'b0;
    done_seen    = 1'b0;
    last_ch      = 0;
    cyc          = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    @(posedge sys_rst);

    // requests are already up, nothing moves until the PHY is ready
    load_round(1'b0);
    test_name   = "idle_before_init";
    test_errors = 0;
    repeat (20)
    begin
      step();
      if (ch_addr_en !== '0)
        plain_error("address enable before init");
      if (ch_slice_wr !== '0)
        plain_error("slice written before init");
      if (rd_addr_empty !== 1'b1)
        plain_error("address queue not empty before init");
      if (round_done)
        plain_error("round_done pulsed before init");
    end
    end_test();

    init_req = 1'b1;
    for (int r = 0; r < N_ROUNDS; r++)
    begin
      test_name   = $sformatf("round_%0d", r);
      test_errors = 0;
      done_seen   = 1'b0;
      while (!done_seen)
        step();
      check_round_end();
      end_test();
      load_round(r + 1 == EMPTY_ROUND);
    end

    $display("summary: %0d tests, %0d failed, %0d check errors, %0d assertion failures",
             tests_run, tests_failed, errors, dut.u_checker.fail_count);
    if (errors == 0 && dut.u_checker.fail_count == 0)
      $display("NO ERRORS");
    else
      $display("ERRORS FOUND");
    $finish;
  end

  // ********************
  // watchdog
  // ********************
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired after %0d ns, rounds did not complete", WATCHDOG_NS);
    $display("ERRORS FOUND");
    $finish;
  end

endmodule

`default_nettype wire

/* sim/rd_fifo_arbiter_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_fifo_arbiter_checker
  import rd_sched_pkg::*, rd_data_pkg::*;
(
  input logic              sys_clk,
  input logic              sys_rst,
  input logic [CH_NUM-1:0] ch_addr_en_i,
  input logic [CH_NUM-1:0] ch_slice_wr_i,
  input level_t            ch_level_i [CH_NUM],
  input logic              rd_addr_valid_i,
  input logic              round_done_i
);

  int                onehot_fails = 0;
  int                level_fails  = 0;
  int                reset_fails  = 0;
  int                fail_count;
  logic [CH_NUM-1:0] level_high;

  assign fail_count = onehot_fails + level_fails + reset_fails;

  always_comb
  begin
    for (int c = 0; c < CH_NUM; c++)
      level_high[c] = (ch_level_i[c] >= level_t'(LEVEL_LIMIT));
  end

  // ********************
  // strobe shape
  // ********************
  a_onehot: assert property (@(posedge sys_clk) disable iff (!sys_rst)
    $onehot0(ch_addr_en_i) && $onehot0(ch_slice_wr_i))
  else
  begin
    onehot_fails++;
    $error("address enables or slice writes are not one-hot");
  end

  // a slice lands one cycle after its pop, so the pop saw the past level
  a_level: assert property (@(posedge sys_clk) disable iff (!sys_rst)
    (ch_slice_wr_i & $past(level_high)) == '0)
  else
  begin
    level_fails++;
    $error("slice written to a channel that was at its level limit");
  end

  // ********************
  // reset
  // ********************
  a_reset_quiet: assert property (@(posedge sys_clk)
    (!sys_rst ##1 !sys_rst) |-> (ch_addr_en_i == '0) && (ch_slice_wr_i == '0) &&
                                !rd_addr_valid_i && !round_done_i)
  else
  begin
    reset_fails++;
    $error("output strobe high during reset");
  end

endmodule

`default_nettype wire

/* sim/tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int HALF_NS    = 2,
  parameter int RST_CYCLES = 5
) (
  output logic sys_clk,
  output logic sys_rst
);

  initial
  begin
    sys_clk = 1'b0;
    forever #(HALF_NS) sys_clk = ~sys_clk;
  end

  // released on a falling edge, clear of the sampling edge
  initial
  begin
    sys_rst = 1'b0;
    repeat (RST_CYCLES) @(posedge sys_clk);
    @(negedge sys_clk);
    sys_rst = 1'b1;
  end

endmodule

`default_nettype wire

/* source/rd_fifo_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_fifo_arbiter
  import rd_sched_pkg::*, rd_data_pkg::*;
(
  input  logic              sys_clk,
  input  logic              sys_rst,
  input  logic              phy_init_done_i,
  input  logic [CH_NUM-1:0] ch_req_i,
  input  addr_t             ch_addr_i [CH_NUM],
  input  level_t            ch_level_i [CH_NUM],
  input  logic              rd_addr_pop_i,
  input  logic              rd_beat_wr_i,
  input  beat_t             rd_beat_i,
  output logic [CH_NUM-1:0] ch_addr_en_o,
  output addr_t             rd_addr_o,
  output logic              rd_addr_valid_o,
  output logic              rd_addr_empty_o,
  output logic [CH_NUM-1:0] ch_slice_wr_o,
  output slice_t            ch_slice_o,
  output logic              round_done_o
);

  logic       aq_wr;
  addr_t      aq_data;
  issue_rec_t issue;
  logic       pk_wr;
  slice_t     pk_slice;
  logic       dq_rd;
  logic       dq_valid;
  logic       dq_empty;
  slice_t     dq_data;

  // ********************
  // address path
  // ********************
  rd_addr_scheduler u_sched (
    .sys_clk         (sys_clk),
    .sys_rst         (sys_rst),
    .phy_init_done_i (phy_init_done_i),
    .round_done_i    (round_done_o),
    .ch_req_i        (ch_req_i),
    .ch_addr_i       (ch_addr_i),
    .ch_addr_en_o    (ch_addr_en_o),
    .aq_wr_o         (aq_wr),
    .aq_data_o       (aq_data),
    .issue_o         (issue)
  );

  sync_fifo #(
    .WIDTH ($bits(addr_t)),
    .DEPTH (ADDR_DEPTH)
  ) u_addr_q (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .wr_i    (aq_wr),
    .din_i   (aq_data),
    .rd_i    (rd_addr_pop_i),
    .dout_o  (rd_addr_o),
    .valid_o (rd_addr_valid_o),
    .empty_o (rd_addr_empty_o)
  );

  // ********************
  // data path
  // ********************
  rd_beat_packer u_packer (
    .sys_clk    (sys_clk),
    .sys_rst    (sys_rst),
    .beat_wr_i  (rd_beat_wr_i),
    .beat_i     (rd_beat_i),
    .slice_wr_o (pk_wr),
    .slice_o    (pk_slice)
  );

  sync_fifo #(
    .WIDTH ($bits(slice_t)),
    .DEPTH (DATA_DEPTH)
  ) u_data_q (
    .sys_clk (sys_clk),
    .sys_rst (sys_rst),
    .wr_i    (pk_wr),
    .din_i   (pk_slice),
    .rd_i    (dq_rd),
    .dout_o  (dq_data),
    .valid_o (dq_valid),
    .empty_o (dq_empty)
  );

  rd_slice_dispatcher u_disp (
    .sys_clk       (sys_clk),
    .sys_rst       (sys_rst),
    .issue_i       (issue),
    .dq_valid_i    (dq_valid),
    .dq_empty_i    (dq_empty),
    .dq_data_i     (dq_data),
    .ch_level_i    (ch_level_i),
    .dq_rd_o       (dq_rd),
    .ch_slice_wr_o (ch_slice_wr_o),
    .ch_slice_o    (ch_slice_o),
    .round_done_o  (round_done_o)
  );

endmodule

`default_nettype wire

/* source/rd_slice_dispatcher.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_slice_dispatcher
  import rd_sched_pkg::*, rd_data_pkg::*;
(
  input  logic              sys_clk,
  input  logic              sys_rst,
  input  issue_rec_t        issue_i,
  input  logic              dq_valid_i,
  input  logic              dq_empty_i,
  input  slice_t            dq_data_i,
  input  level_t            ch_level_i [CH_NUM],
  output logic              dq_rd_o,
  output logic [CH_NUM-1:0] ch_slice_wr_o,
  output slice_t            ch_slice_o,
  output logic              round_done_o
);

  disp_state_t       state_q;
  ch_idx_t           cur_ch_q;
  ch_idx_t           next_ch;
  cnt_t              cnt_q [CH_NUM];
  logic [CH_NUM-1:0] ready_q;
  cnt_t              popped_q;
  cnt_t              deliv_q;
  cnt_t              cur_cnt;
  logic              level_ok;
  logic              last_ch;
  logic              advance;

  assign cur_cnt  = cnt_q[cur_ch_q];
  assign next_ch  = cur_ch_q + 1'b1;
  assign last_ch  = (cur_ch_q == ch_idx_t'(CH_NUM - 1));
  assign level_ok = (ch_level_i[cur_ch_q] < level_t'(LEVEL_LIMIT));

  // pop only what the channel asked for, and only while it has room
  assign dq_rd_o = (state_q == rd_data_pkg::SERVE) && (popped_q < cur_cnt) &&
                   !dq_empty_i && level_ok;

  // all of the current channel's slices are out
  always_comb
  begin
    case (state_q)
      rd_data_pkg::SERVE: advance = (popped_q == cur_cnt) && (deliv_q == cur_cnt);
      DRAIN:              advance = dq_valid_i && (deliv_q + 1'b1 == cur_cnt);
      default:            advance = 1'b0;
    endcase
  end

  // ********************
  // channel outputs
  // ********************
  always_comb
  begin
    for (int i = 0; i < CH_NUM; i++)
      ch_slice_wr_o[i] = dq_valid_i && (cur_ch_q == ch_idx_t'(i));
  end

  assign ch_slice_o = dq_data_i;

  // counts from the scheduler, qualified by ready_q
  always_ff @(posedge sys_clk)
  begin
    if (issue_i.valid)
      cnt_q[issue_i.ch] <= issue_i.count;
  end

  // ********************
  // round walk
  // ********************
  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
    begin
      state_q      <= WAIT;
      cur_ch_q     <= '0;
      ready_q      <= '0;
      popped_q     <= '0;
      deliv_q      <= '0;
      round_done_o <= 1'b0;
    end
    else
    begin
      round_done_o <= 1'b0;
      if (dq_rd_o)
        popped_q <= popped_q + 1'b1;
      if (dq_valid_i)
        deliv_q <= deliv_q + 1'b1;

      case (state_q)
        WAIT:
        begin
          if (ready_q[cur_ch_q])
            state_q <= rd_data_pkg::SERVE;
        end
        rd_data_pkg::SERVE:
        begin
          // last pop issued, wait for its slice
          if (dq_rd_o && (popped_q + 1'b1 == cur_cnt))
            state_q <= DRAIN;
        end
        default:
        begin
          state_q <= state_q;
        end
      endcase

      if (advance)
      begin
        popped_q <= '0;
        deliv_q  <= '0;
        if (last_ch)
        begin
          round_done_o <= 1'b1;
          ready_q      <= '0;
          cur_ch_q     <= '0;
          state_q      <= WAIT;
        end
        else
        begin
          cur_ch_q <= next_ch;
          state_q  <= ready_q[next_ch] ? rd_data_pkg::SERVE : WAIT;
        end
      end

      if (issue_i.valid)
        ready_q[issue_i.ch] <= 1'b1;
    end
  end

endmodule

`default_nettype wire

/* source/rd_beat_packer.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_beat_packer
  import rd_data_pkg::*;
(
  input  logic   sys_clk,
  input  logic   sys_rst,
  input  logic   beat_wr_i,
  input  beat_t  beat_i,
  output logic   slice_wr_o,
  output slice_t slice_o
);

  // high when the next beat is the upper half
  logic  phase_q;
  beat_t low_q;

  // ********************
  // pair tracking
  // ********************
  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
    begin
      phase_q    <= 1'b0;
      slice_wr_o <= 1'b0;
    end
    else
    begin
      slice_wr_o <= beat_wr_i && phase_q;
      if (beat_wr_i)
        phase_q <= ~phase_q;
    end
  end

  // low beat waits, high beat completes the slice
  always_ff @(posedge sys_clk)
  begin
    if (beat_wr_i)
    begin
      if (!phase_q)
        low_q <= beat_i;
      else
        slice_o <= {beat_i, low_q};
    end
  end

endmodule

`default_nettype wire

/* source/rd_addr_scheduler.sv */
`timescale 1ns/1ps
`default_nettype none

module rd_addr_scheduler
  import rd_sched_pkg::*;
(
  input  logic              sys_clk,
  input  logic              sys_rst,
  input  logic              phy_init_done_i,
  input  logic              round_done_i,
  input  logic [CH_NUM-1:0] ch_req_i,
  input  addr_t             ch_addr_i [CH_NUM],
  output logic [CH_NUM-1:0] ch_addr_en_o,
  output logic              aq_wr_o,
  output addr_t             aq_data_o,
  output issue_rec_t        issue_o
);

  sched_state_t      state_q;
  logic [CH_NUM-1:0] grant_q;
  ch_idx_t           cur_ch_q;
  cnt_t              cnt_q [CH_NUM];
  logic              init_q1;
  logic              init_q2;
  logic              start;
  logic              cur_req;
  cnt_t              cur_cnt;
  logic              accept;
  logic              leave;
  logic              last_ch;

  // ********************
  // start of round
  // ********************
  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
    begin
      init_q1 <= 1'b0;
      init_q2 <= 1'b0;
    end
    else
    begin
      init_q1 <= phy_init_done_i;
      init_q2 <= init_q1;
    end
  end

  // first round on the init edge, later rounds on round_done
  assign start = (init_q1 && !init_q2) || round_done_i;

  // ********************
  // address acceptance
  // ********************
  assign cur_req   = ch_req_i[cur_ch_q];
  assign cur_cnt   = cnt_q[cur_ch_q];
  assign aq_data_o = ch_addr_i[cur_ch_q];
  assign last_ch   = (cur_ch_q == ch_idx_t'(CH_NUM - 1));

  // accept and leave never hold in the same cycle
  assign accept = (state_q == SERVE) && cur_req && (cur_cnt < cnt_t'(SLICE_NUM));
  assign leave  = (state_q == SERVE) && (!cur_req || (cur_cnt == cnt_t'(SLICE_NUM)));

  assign aq_wr_o      = accept;
  assign ch_addr_en_o = grant_q & {CH_NUM{accept}};

  // accepted addresses per channel, cleared when the round ends
  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
      cnt_q <= '{default: '0};
    else if (round_done_i)
      cnt_q <= '{default: '0};
    else if (accept)
      cnt_q[cur_ch_q] <= cur_cnt + 1'b1;
  end

  // ********************
  // channel walk
  // ********************
  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
    begin
      state_q  <= IDLE;
      grant_q  <= '0;
      cur_ch_q <= '0;
      issue_o  <= '0;
    end
    else
    begin
      issue_o <= '0;
      case (state_q)
        IDLE:
        begin
          if (start)
          begin
            state_q  <= SERVE;
            grant_q  <= CH_NUM'(1);
            cur_ch_q <= '0;
          end
        end
        SERVE:
        begin
          if (leave)
          begin
            // tell the dispatcher how many slices this channel expects
            issue_o.valid <= 1'b1;
            issue_o.ch    <= cur_ch_q;
            issue_o.count <= cur_cnt;
            if (last_ch)
            begin
              state_q <= IDLE;
              grant_q <= '0;
            end
            else
            begin
              grant_q  <= grant_q << 1;
              cur_ch_q <= cur_ch_q + 1'b1;
            end
          end
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/sync_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module sync_fifo #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 64
) (
  input  logic             sys_clk,
  input  logic             sys_rst,
  input  logic             wr_i,
  input  logic [WIDTH-1:0] din_i,
  input  logic             rd_i,
  output logic [WIDTH-1:0] dout_o,
  output logic             valid_o,
  output logic             empty_o
);

  localparam int AW = $clog2(DEPTH);

  logic [WIDTH-1:0] mem [DEPTH];
  // extra top bit tells a full queue from an empty one
  logic [AW:0]      wptr_q;
  logic [AW:0]      rptr_q;
  logic             do_rd;

  assign empty_o = (wptr_q == rptr_q);
  assign do_rd   = rd_i && !empty_o;

  // storage
  always_ff @(posedge sys_clk)
  begin
    if (wr_i)
      mem[wptr_q[AW-1:0]] <= din_i;
  end

  // registered read port
  always_ff @(posedge sys_clk)
  begin
    if (do_rd)
      dout_o <= mem[rptr_q[AW-1:0]];
  end

  always_ff @(posedge sys_clk)
  begin
    if (!sys_rst)
    begin
      wptr_q  <= '0;
      rptr_q  <= '0;
      valid_o <= 1'b0;
    end
    else
    begin
      if (wr_i)
        wptr_q <= wptr_q + 1'b1;
      if (do_rd)
        rptr_q <= rptr_q + 1'b1;
      // data shows up one cycle after the read
      valid_o <= do_rd;
    end
  end

endmodule

`default_nettype wire

/* source/rd_data_pkg.sv */
`default_nettype none

// ********************
// data side of the read path
// ********************
package rd_data_pkg;

  // controller beat and packed channel slice
  typedef logic [63:0]  beat_t;
  typedef logic [127:0] slice_t;

  // fill level reported by a channel read FIFO
  typedef logic [5:0] level_t;

  // no slice goes to a channel at or above this level
  localparam int LEVEL_LIMIT = 60;

  // both queues hold at least one full round
  localparam int ADDR_DEPTH = 64;
  localparam int DATA_DEPTH = 64;

  // dispatcher FSM
  typedef enum logic [1:0] {
    WAIT,
    SERVE,
    DRAIN
  } disp_state_t;

endpackage

`default_nettype wire

/* source/rd_sched_pkg.sv */
`default_nettype none

// ********************
// address side of the read scheduler
// ********************
package rd_sched_pkg;

  // channels visited per round, fixed order 0 to CH_NUM-1
  localparam int CH_NUM = 6;

  // most bursts taken from one channel in one round
  localparam int SLICE_NUM = 8;

  // burst address as seen by the memory controller
  typedef logic [29:0] addr_t;

  // channel number
  typedef logic [2:0] ch_idx_t;

  // per channel slice count, 0 to SLICE_NUM
  typedef logic [3:0] cnt_t;

  // one record per channel, sent when the scheduler leaves it
  typedef struct packed {
    logic    valid;
    ch_idx_t ch;
    cnt_t    count;
  } issue_rec_t;

  // scheduler FSM
  typedef enum logic {
    IDLE,
    SERVE
  } sched_state_t;

endpackage

`default_nettype wire
